// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;
    localparam int NREG = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    // major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam word_t TX_ADDR = 32'h0002_0020;   // uart tx byte

    // OP_NOP must stay at zero, flushed stages rely on it
    typedef enum logic [5:0] {
        OP_NOP,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_SB,
        OP_ADDI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND
    } op_e;

    typedef struct packed {
        word_t pc;
        logic  valid;
    } fd_t;

    typedef struct packed {
        op_e       op;
        reg_addr_t rd;
        word_t     a;     // rs1 value
        word_t     b;     // rs2 value
        word_t     imm;
        word_t     pc;
    } de_t;

endpackage

`default_nettype wire

// ==== hw/stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      i_flush,
    input  payload_t i_d,
    output payload_t o_q
);

    // cleared payload decodes as an invalid slot / nop
    always_ff @(posedge clk) begin
        if (reset || i_flush) begin
            o_q <= payload_t'(0);
        end else begin
            o_q <= i_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire                clk,
    input  wire                reset,
    input  wire                i_jump,
    input  wire rv_pkg::word_t i_jump_target,
    output rv_pkg::word_t      o_pc,
    output rv_pkg::fd_t        o_fd
);

    rv_pkg::word_t pc;
    rv_pkg::word_t pc_plus;
    rv_pkg::word_t next_pc;

    assign pc_plus = pc + 32'd4;
    assign next_pc = i_jump ? i_jump_target : pc_plus;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign o_pc = pc;

    // word fetched while execute redirects is on the wrong path
    assign o_fd.pc    = pc;
    assign o_fd.valid = ~i_jump;

endmodule

`default_nettype wire

// ==== hw/decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode (
    input  wire rv_pkg::word_t  i_inst,
    input  wire rv_pkg::fd_t    i_fd,
    output rv_pkg::reg_addr_t   o_rs1,
    output rv_pkg::reg_addr_t   o_rs2,
    input  wire rv_pkg::word_t  i_rs1_val,
    input  wire rv_pkg::word_t  i_rs2_val,
    output rv_pkg::de_t         o_de
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          sign;
    rv_pkg::word_t imm_i;
    rv_pkg::word_t imm_s;
    rv_pkg::word_t imm_b;
    rv_pkg::word_t imm_u;
    rv_pkg::word_t imm_j;
    rv_pkg::op_e   op;
    rv_pkg::word_t imm;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign sign   = i_inst[31];

    assign imm_i = {{20{sign}}, i_inst[31:20]};
    assign imm_s = {{20{sign}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{20{sign}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'h000};
    assign imm_j = {{12{sign}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    assign o_rs1 = i_inst[19:15];
    assign o_rs2 = i_inst[24:20];

    always_comb begin
        op  = rv_pkg::OP_NOP;
        imm = imm_i;
        case (opcode)
            rv_pkg::OPC_LUI: begin
                op  = rv_pkg::OP_LUI;
                imm = imm_u;
            end
            rv_pkg::OPC_AUIPC: begin
                op  = rv_pkg::OP_AUIPC;
                imm = imm_u;
            end
            rv_pkg::OPC_JAL: begin
                op  = rv_pkg::OP_JAL;
                imm = imm_j;
            end
            rv_pkg::OPC_JALR: begin
                if (funct3 == 3'b000) op = rv_pkg::OP_JALR;
            end
            rv_pkg::OPC_BRANCH: begin
                imm = imm_b;
                case (funct3)
                    3'b000: op = rv_pkg::OP_BEQ;
                    3'b001: op = rv_pkg::OP_BNE;
                    3'b100: op = rv_pkg::OP_BLT;
                    3'b101: op = rv_pkg::OP_BGE;
                    3'b110: op = rv_pkg::OP_BLTU;
                    3'b111: op = rv_pkg::OP_BGEU;
                    default: op = rv_pkg::OP_NOP;
                endcase
            end
            rv_pkg::OPC_STORE: begin
                imm = imm_s;
                if (funct3 == 3'b000) op = rv_pkg::OP_SB;   // sh/sw dropped
            end
            rv_pkg::OPC_OPIMM: begin
                case (funct3)
                    3'b000: op = rv_pkg::OP_ADDI;
                    3'b010: op = rv_pkg::OP_SLTI;
                    3'b011: op = rv_pkg::OP_SLTIU;
                    3'b100: op = rv_pkg::OP_XORI;
                    3'b110: op = rv_pkg::OP_ORI;
                    3'b111: op = rv_pkg::OP_ANDI;
                    3'b001: if (funct7 == 7'b0000000) op = rv_pkg::OP_SLLI;
                    default: begin
                        if (funct7 == 7'b0000000) op = rv_pkg::OP_SRLI;
                        else if (funct7 == 7'b0100000) op = rv_pkg::OP_SRAI;
                    end
                endcase
            end
            rv_pkg::OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: op = rv_pkg::OP_ADD;
                    10'b0100000_000: op = rv_pkg::OP_SUB;
                    10'b0000000_001: op = rv_pkg::OP_SLL;
                    10'b0000000_010: op = rv_pkg::OP_SLT;
                    10'b0000000_011: op = rv_pkg::OP_SLTU;
                    10'b0000000_100: op = rv_pkg::OP_XOR;
                    10'b0000000_101: op = rv_pkg::OP_SRL;
                    10'b0100000_101: op = rv_pkg::OP_SRA;
                    10'b0000000_110: op = rv_pkg::OP_OR;
                    10'b0000000_111: op = rv_pkg::OP_AND;
                    default: op = rv_pkg::OP_NOP;
                endcase
            end
            default: op = rv_pkg::OP_NOP;     // unknown opcodes run as nop
        endcase
    end

    assign o_de.op  = i_fd.valid ? op : rv_pkg::OP_NOP;   // squashed slot
    assign o_de.rd  = i_inst[11:7];
    assign o_de.a   = i_rs1_val;
    assign o_de.b   = i_rs2_val;
    assign o_de.imm = imm;
    assign o_de.pc  = i_fd.pc;

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  wire                    clk,
    input  wire rv_pkg::reg_addr_t i_rs1,
    input  wire rv_pkg::reg_addr_t i_rs2,
    output rv_pkg::word_t          o_rs1_val,
    output rv_pkg::word_t          o_rs2_val,
    input  wire                    i_we,
    input  wire rv_pkg::reg_addr_t i_wd,
    input  wire rv_pkg::word_t     i_wdata,
    input  wire                    i_byp_we,
    input  wire rv_pkg::reg_addr_t i_byp_rd,
    input  wire rv_pkg::word_t     i_byp_val
);

    rv_pkg::word_t regs [1:rv_pkg::NREG-1];   // x0 is not stored

    always_ff @(posedge clk) begin
        if (i_we) begin
            regs[i_wd] <= i_wdata;
        end
    end

    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t idx);
        rv_pkg::word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (i_byp_we && (i_byp_rd == idx)) begin
            val = i_byp_val;          // forward from execute
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        o_rs1_val = read_port(i_rs1);
        o_rs2_val = read_port(i_rs2);
    end

endmodule

`default_nettype wire

// ==== hw/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute (
    input  wire rv_pkg::de_t  i_de,
    output logic              o_jump,
    output rv_pkg::word_t     o_jump_target,
    output rv_pkg::word_t     o_result,
    output rv_pkg::reg_addr_t o_rd,
    output logic              o_we,
    output logic              o_tx_en,
    output logic [7:0]        o_tx_byte
);

    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t imm;
    rv_pkg::word_t pc;
    rv_pkg::word_t link;
    rv_pkg::word_t addr;
    logic [4:0]    shamt;
    logic          eq;
    logic          lt;
    logic          ltu;
    logic          lti;
    logic          ltiu;
    logic          taken;

    assign a     = i_de.a;
    assign b     = i_de.b;
    assign imm   = i_de.imm;
    assign pc    = i_de.pc;
    assign link  = pc + 32'd4;
    assign addr  = a + imm;          // store and jalr address
    assign shamt = imm[4:0];

    assign eq   = (a == b);
    assign lt   = ($signed(a) < $signed(b));
    assign ltu  = (a < b);
    assign lti  = ($signed(a) < $signed(imm));
    assign ltiu = (a < imm);

    always_comb begin
        o_result = '0;
        o_we     = 1'b1;
        case (i_de.op)
            rv_pkg::OP_LUI:   o_result = imm;
            rv_pkg::OP_AUIPC: o_result = pc + imm;
            rv_pkg::OP_JAL:   o_result = link;
            rv_pkg::OP_JALR:  o_result = link;
            rv_pkg::OP_ADDI:  o_result = a + imm;
            rv_pkg::OP_SLTI:  o_result = {31'd0, lti};
            rv_pkg::OP_SLTIU: o_result = {31'd0, ltiu};
            rv_pkg::OP_XORI:  o_result = a ^ imm;
            rv_pkg::OP_ORI:   o_result = a | imm;
            rv_pkg::OP_ANDI:  o_result = a & imm;
            rv_pkg::OP_SLLI:  o_result = a << shamt;
            rv_pkg::OP_SRLI:  o_result = a >> shamt;
            rv_pkg::OP_SRAI:  o_result = $signed(a) >>> shamt;
            rv_pkg::OP_ADD:   o_result = a + b;
            rv_pkg::OP_SUB:   o_result = a - b;
            rv_pkg::OP_SLL:   o_result = a << b[4:0];
            rv_pkg::OP_SLT:   o_result = {31'd0, lt};
            rv_pkg::OP_SLTU:  o_result = {31'd0, ltu};
            rv_pkg::OP_XOR:   o_result = a ^ b;
            rv_pkg::OP_SRL:   o_result = a >> b[4:0];
            rv_pkg::OP_SRA:   o_result = $signed(a) >>> b[4:0];
            rv_pkg::OP_OR:    o_result = a | b;
            rv_pkg::OP_AND:   o_result = a & b;
            default:          o_we = 1'b0;   // nop, branches, sb
        endcase
    end

    always_comb begin
        case (i_de.op)
            rv_pkg::OP_BEQ:  taken = eq;
            rv_pkg::OP_BNE:  taken = ~eq;
            rv_pkg::OP_BLT:  taken = lt;
            rv_pkg::OP_BGE:  taken = ~lt;
            rv_pkg::OP_BLTU: taken = ltu;
            rv_pkg::OP_BGEU: taken = ~ltu;
            default:         taken = 1'b0;
        endcase
    end

    assign o_jump = taken || (i_de.op == rv_pkg::OP_JAL) || (i_de.op == rv_pkg::OP_JALR);
    assign o_jump_target = (i_de.op == rv_pkg::OP_JALR) ? {addr[31:1], 1'b0} : pc + imm;

    assign o_rd = i_de.rd;

    // only the uart byte address has a target, other stores vanish
    assign o_tx_en   = (i_de.op == rv_pkg::OP_SB) && (addr == rv_pkg::TX_ADDR);
    assign o_tx_byte = b[7:0];

endmodule

`default_nettype wire

// ==== hw/result.sv ====
`timescale 1ns/1ps
`default_nettype none

module result (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    i_we,
    input  wire rv_pkg::reg_addr_t i_rd,
    input  wire rv_pkg::word_t     i_result,
    input  wire                    i_tx_en,
    input  wire [7:0]              i_tx_byte,
    output logic                   o_rf_we,
    output rv_pkg::reg_addr_t      o_rf_wd,
    output rv_pkg::word_t          o_rf_wdata,
    output logic                   o_tx_valid,
    output logic [7:0]             o_tx_data
);

    assign o_rf_we    = i_we && (i_rd != '0);   // x0 stays zero
    assign o_rf_wd    = i_rd;
    assign o_rf_wdata = i_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            o_tx_valid <= 1'b0;
        end else begin
            o_tx_valid <= i_tx_en;
        end
    end

    always_ff @(posedge clk) begin
        if (i_tx_en) begin
            o_tx_data <= i_tx_byte;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
    input  wire                clk,
    input  wire                reset,
    output rv_pkg::word_t      o_pc,
    input  wire rv_pkg::word_t i_inst,
    output logic               o_tx_valid,
    output logic [7:0]         o_tx_data
);

    rv_pkg::fd_t       fd_d;
    rv_pkg::fd_t       fd_q;
    rv_pkg::de_t       de_d;
    rv_pkg::de_t       de_q;
    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    rv_pkg::word_t     rs1_val;
    rv_pkg::word_t     rs2_val;
    logic              jump;
    rv_pkg::word_t     jump_target;
    rv_pkg::word_t     ex_result;
    rv_pkg::reg_addr_t ex_rd;
    logic              ex_we;
    logic              tx_en;
    logic [7:0]        tx_byte;
    logic              rf_we;
    rv_pkg::reg_addr_t rf_wd;
    rv_pkg::word_t     rf_wdata;

    fetch_unit i_fetch_unit (
        .clk(clk), .reset(reset), .i_jump(jump), .i_jump_target(jump_target),
        .o_pc(o_pc), .o_fd(fd_d)
    );

    stage_reg #(.payload_t(rv_pkg::fd_t)) i_fd_reg (
        .clk(clk), .reset(reset), .i_flush(jump), .i_d(fd_d), .o_q(fd_q)
    );

    decode i_decode (
        .i_inst(i_inst), .i_fd(fd_q), .o_rs1(rs1), .o_rs2(rs2),
        .i_rs1_val(rs1_val), .i_rs2_val(rs2_val), .o_de(de_d)
    );

    register_file i_register_file (
        .clk(clk), .i_rs1(rs1), .i_rs2(rs2), .o_rs1_val(rs1_val), .o_rs2_val(rs2_val),
        .i_we(rf_we), .i_wd(rf_wd), .i_wdata(rf_wdata),
        .i_byp_we(ex_we), .i_byp_rd(ex_rd), .i_byp_val(ex_result)
    );

    stage_reg #(.payload_t(rv_pkg::de_t)) i_de_reg (
        .clk(clk), .reset(reset), .i_flush(jump), .i_d(de_d), .o_q(de_q)
    );

    execute i_execute (
        .i_de(de_q), .o_jump(jump), .o_jump_target(jump_target),
        .o_result(ex_result), .o_rd(ex_rd), .o_we(ex_we),
        .o_tx_en(tx_en), .o_tx_byte(tx_byte)
    );

    result i_result (
        .clk(clk), .reset(reset), .i_we(ex_we), .i_rd(ex_rd), .i_result(ex_result),
        .i_tx_en(tx_en), .i_tx_byte(tx_byte),
        .o_rf_we(rf_we), .o_rf_wd(rf_wd), .o_rf_wdata(rf_wdata),
        .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int ROM_WORDS = 256;
    localparam rv_pkg::word_t NOP_WORD = 32'h0000_0013;   // addi x0, x0, 0
    localparam rv_pkg::reg_addr_t BASE = 5'd31;           // holds TX_ADDR
    localparam rv_pkg::reg_addr_t TMP  = 5'd30;

    logic          clk;
    logic          reset;
    rv_pkg::word_t i_inst;
    rv_pkg::word_t o_pc;
    logic          o_tx_valid;
    logic [7:0]    o_tx_data;

    rv_pkg::word_t rom [0:ROM_WORDS-1];
    rv_pkg::word_t prog [0:ROM_WORDS-1];
    int            prog_len;
    rv_pkg::word_t end_pc;
    logic [7:0]    exp_q [$];
    int            rx_count;
    logic [15:0]   lfsr;
    string         test_name;
    int            errors;
    int            checks;
    int            tests;
    int            wd_count;
    int            wd_limit;
    logic          wd_armed;

    rv_core_top i_rv_core_top (
        .clk(clk), .reset(reset), .o_pc(o_pc), .i_inst(i_inst),
        .o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // registered instruction memory, one cycle behind o_pc
    always @(posedge clk) begin
        i_inst <= (o_pc[31:10] == '0) ? rom[o_pc[9:2]] : NOP_WORD;
    end

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s expected %02h actual %02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t exp,
                              input rv_pkg::word_t act);
        checks++;
        if (exp !== act) begin
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
            errors++;
        end
    endtask

    // strobes checked in order against the model's byte list
    always @(negedge clk) begin
        if (!reset && o_tx_valid) begin
            if (rx_count < exp_q.size()) begin
                check_byte(test_name, exp_q[rx_count], o_tx_data);
            end else begin
                $display("test %s: transmit strobe beyond the expected bytes, data %02h",
                         test_name, o_tx_data);
                errors++;
            end
            rx_count++;
        end
    end

    always @(negedge clk) begin
        if (wd_armed) begin
            wd_count++;
            if (wd_count > wd_limit) begin
                $display("test %s: timed out after %0d cycles", test_name, wd_limit);
                $display("Errors found");
                $finish;
            end
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic rv_pkg::reg_addr_t rand_reg();
        logic [31:0] t;
        t = rand_bits(3);
        return rv_pkg::reg_addr_t'(t[2:0]) + 5'd1;   // x1..x8
    endfunction

    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input rv_pkg::reg_addr_t rs2,
                                            input rv_pkg::reg_addr_t rs1, input logic [2:0] f3,
                                            input rv_pkg::reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, rv_pkg::OPC_OP};
    endfunction

    function automatic rv_pkg::word_t enc_i(input logic [11:0] imm, input rv_pkg::reg_addr_t rs1,
                                            input logic [2:0] f3, input rv_pkg::reg_addr_t rd,
                                            input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv_pkg::word_t enc_sb(input logic [11:0] imm, input rv_pkg::reg_addr_t rs2,
                                             input rv_pkg::reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [12:0] imm, input rv_pkg::reg_addr_t rs2,
                                            input rv_pkg::reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::word_t enc_j(input logic [20:0] imm, input rv_pkg::reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OPC_JAL};
    endfunction

    function automatic void emit(input rv_pkg::word_t w);
        prog[prog_len] = w;
        prog_len++;
    endfunction

    function automatic void start_program();
        for (int i = 0; i < ROM_WORDS; i++) prog[i] = NOP_WORD;
        prog_len = 0;
        emit({20'h00020, BASE, rv_pkg::OPC_LUI});
        emit(enc_i(12'h020, BASE, 3'b000, BASE, rv_pkg::OPC_OPIMM));
    endfunction

    function automatic void send(input rv_pkg::reg_addr_t r);
        emit(enc_sb(12'h000, r, BASE));
    endfunction

    function automatic void send_word(input rv_pkg::reg_addr_t r);
        send(r);
        for (int s = 8; s < 32; s += 8) begin
            emit(enc_i({7'd0, 5'(s)}, r, 3'b101, TMP, rv_pkg::OPC_OPIMM));   // srli
            send(TMP);
        end
    endfunction

    function automatic void init_regs();
        logic [31:0] t;
        for (int r = 1; r <= 8; r++) begin
            t = rand_bits(12);
            emit(enc_i(t[11:0], 5'd0, 3'b000, 5'(r), rv_pkg::OPC_OPIMM));   // no regfile reset
        end
    endfunction

    // short block of transmit stores, used as skipped or kept code
    function automatic void tx_block(input int n);
        logic [31:0] t;
        for (int k = 0; k < n; k++) begin
            t = rand_bits(12);
            emit(enc_i(t[11:0], 5'd0, 3'b000, TMP, rv_pkg::OPC_OPIMM));
            send(TMP);
        end
    endfunction

    function automatic rv_pkg::word_t random_alu(input rv_pkg::reg_addr_t rd);
        rv_pkg::reg_addr_t rs1;
        rv_pkg::reg_addr_t rs2;
        logic [31:0]       t;
        logic [11:0]       imm;
        logic [3:0]        sel;
        rv_pkg::word_t     w;
        rs1 = rand_reg();
        rs2 = rand_reg();
        t   = rand_bits(12);
        imm = t[11:0];
        t   = rand_bits(4);
        sel = t[3:0];
        case (sel)
            4'd0:  w = enc_r(7'h00, rs2, rs1, 3'd0, rd);
            4'd1:  w = enc_r(7'h20, rs2, rs1, 3'd0, rd);   // sub
            4'd2:  w = enc_r(7'h00, rs2, rs1, 3'd1, rd);
            4'd3:  w = enc_r(7'h00, rs2, rs1, 3'd2, rd);
            4'd4:  w = enc_r(7'h00, rs2, rs1, 3'd3, rd);
            4'd5:  w = enc_r(7'h00, rs2, rs1, 3'd4, rd);
            4'd6:  w = enc_r(7'h00, rs2, rs1, 3'd5, rd);
            4'd7:  w = enc_r(7'h20, rs2, rs1, 3'd5, rd);   // sra
            4'd8:  w = enc_r(7'h00, rs2, rs1, 3'd6, rd);
            4'd9:  w = enc_r(7'h00, rs2, rs1, 3'd7, rd);
            4'd10: w = enc_i(imm, rs1, 3'd0, rd, rv_pkg::OPC_OPIMM);
            4'd11: w = enc_i(imm, rs1, 3'd2, rd, rv_pkg::OPC_OPIMM);
            4'd12: w = enc_i(imm, rs1, 3'd3, rd, rv_pkg::OPC_OPIMM);
            4'd13: w = enc_i(imm, rs1, imm[1] ? 3'd4 : 3'd6, rd, rv_pkg::OPC_OPIMM);
            4'd14: w = enc_i(imm, rs1, 3'd7, rd, rv_pkg::OPC_OPIMM);
            default: begin
                if (imm[11])      w = enc_i({7'h20, imm[4:0]}, rs1, 3'd5, rd, rv_pkg::OPC_OPIMM);
                else if (imm[10]) w = enc_i({7'h00, imm[4:0]}, rs1, 3'd5, rd, rv_pkg::OPC_OPIMM);
                else              w = enc_i({7'h00, imm[4:0]}, rs1, 3'd1, rd, rv_pkg::OPC_OPIMM);
            end
        endcase
        return w;
    endfunction

    // sequential RV32I model of the generated program
    task automatic run_model();
        rv_pkg::word_t r [0:31];
        rv_pkg::word_t pc;
        rv_pkg::word_t nxt;
        rv_pkg::word_t w;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t ii;
        rv_pkg::word_t is;
        rv_pkg::word_t ib;
        rv_pkg::word_t ij;
        rv_pkg::word_t res;
        logic          wr;
        logic          tk;
        logic          done;
        int            steps;
        for (int i = 0; i < 32; i++) r[i] = '0;
        exp_q.delete();
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4 * ROM_WORDS) begin
            w   = prog[pc[9:2]];
            a   = r[w[19:15]];
            b   = r[w[24:20]];
            ii  = {{20{w[31]}}, w[31:20]};
            is  = {{20{w[31]}}, w[31:25], w[11:7]};
            ib  = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            ij  = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            nxt = pc + 32'd4;
            res = '0;
            wr  = 1'b1;
            tk  = 1'b0;
            case (w[6:0])
                rv_pkg::OPC_LUI:   res = {w[31:12], 12'h000};
                rv_pkg::OPC_AUIPC: res = pc + {w[31:12], 12'h000};
                rv_pkg::OPC_JAL: begin
                    res  = pc + 32'd4;
                    nxt  = pc + ij;
                    done = (ij == '0);
                end
                rv_pkg::OPC_JALR: begin
                    res = pc + 32'd4;
                    nxt = (a + ii) & ~32'd1;
                end
                rv_pkg::OPC_BRANCH: begin
                    wr = 1'b0;
                    case (w[14:12])
                        3'd0: tk = (a == b);
                        3'd1: tk = (a != b);
                        3'd4: tk = ($signed(a) < $signed(b));
                        3'd5: tk = ($signed(a) >= $signed(b));
                        3'd6: tk = (a < b);
                        default: tk = (a >= b);
                    endcase
                    if (tk) nxt = pc + ib;
                end
                rv_pkg::OPC_STORE: begin
                    wr = 1'b0;
                    if (w[14:12] == 3'd0 && (a + is) == rv_pkg::TX_ADDR) exp_q.push_back(b[7:0]);
                end
                default: begin
                    if (w[6:0] == rv_pkg::OPC_OP) ii = b;   // register operand
                    case (w[14:12])
                        3'd0: res = (w[6:0] == rv_pkg::OPC_OP && w[30]) ? a - ii : a + ii;
                        3'd1: res = a << ii[4:0];
                        3'd2: res = {31'd0, $signed(a) < $signed(ii)};
                        3'd3: res = {31'd0, a < ii};
                        3'd4: res = a ^ ii;
                        3'd5: res = w[30] ? $signed(a) >>> ii[4:0] : a >> ii[4:0];
                        3'd6: res = a | ii;
                        default: res = a & ii;
                    endcase
                end
            endcase
            if (wr && w[11:7] != 5'd0) r[w[11:7]] = res;
            pc = nxt;
            steps++;
        end
        end_pc = pc;
        if (!done) begin
            $display("test %s: model never reached the closing loop", test_name);
            errors++;
        end
    endtask

    task automatic run_test(input string name);
        int err_start;
        test_name = name;
        tx_block(1);                    // closing marker byte
        emit(enc_j(21'd0, 5'd0));
        run_model();
        err_start = errors;
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = prog[i];
        rx_count = 0;
        wd_count = 0;
        wd_limit = prog_len * 4 + 50;
        wd_armed = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_word({name, "_reset_pc"}, '0, o_pc);
        if (o_tx_valid) begin
            $display("test %s: transmit strobe high right after reset", name);
            errors++;
        end
        while (rx_count < exp_q.size()) @(negedge clk);
        while (o_pc != end_pc) @(negedge clk);
        repeat (3) @(negedge clk);
        check_word({name, "_end_pc"}, end_pc, o_pc);
        repeat (6) @(negedge clk);
        if (rx_count != exp_q.size()) begin
            $display("test %s: %0d strobes seen, %0d expected", name, rx_count, exp_q.size());
            errors++;
        end
        wd_armed = 1'b0;
        tests++;
        $display("test %-8s strobes %0d/%0d, errors %0d", name, rx_count, exp_q.size(),
                 errors - err_start);
    endtask

    initial begin
        logic [31:0]       t;
        rv_pkg::reg_addr_t rd;
        int                n;
        reset    = 1'b1;
        i_inst   = NOP_WORD;
        lfsr     = 16'd52;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        rx_count = 0;
        wd_armed = 1'b0;
        wd_count = 0;
        wd_limit = 0;

        start_program();                // dependent chain and x0 writes
        emit(enc_i(12'h123, 5'd0, 3'd0, 5'd1, rv_pkg::OPC_OPIMM));
        for (int k = 0; k < 6; k++) begin
            t = rand_bits(12);
            emit(enc_i(t[11:0], 5'd1, 3'd0, 5'd1, rv_pkg::OPC_OPIMM));
            send(5'd1);
        end
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2));
        send(5'd2);
        emit(enc_i(12'h05a, 5'd1, 3'd0, 5'd0, rv_pkg::OPC_OPIMM));
        send(5'd0);
        emit(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd3));
        send(5'd3);
        run_test("forward");

        start_program();
        init_regs();
        for (int k = 0; k < 24; k++) begin
            t  = rand_bits(3);
            rd = (t[2:0] == 3'd0) ? 5'd0 : rand_reg();
            emit(random_alu(rd));
            t = rand_bits(1);
            if (t[0]) send(rd);
        end
        for (int r = 1; r <= 8; r++) send(5'(r));
        run_test("alu");

        start_program();
        init_regs();
        for (int k = 0; k < 12; k++) begin
            t = rand_bits(3);
            n = 1 + int'(rand_bits(2)) % 3;
            emit(enc_b(13'((2 * n + 1) * 4), rand_reg(), rand_reg(),
                       (t % 6 < 2) ? 3'(t % 6) : 3'(t % 6 + 2)));
            tx_block(n);
            emit(random_alu(rand_reg()));
        end
        run_test("branch");

        start_program();
        for (int k = 0; k < 2; k++) begin
            t  = rand_bits(20);
            rd = rand_reg();
            emit({t[19:0], rd, rv_pkg::OPC_LUI});
            send_word(rd);
            t = rand_bits(20);
            emit({t[19:0], 5'd4, rv_pkg::OPC_AUIPC});
            send_word(5'd4);
            n = 1 + int'(rand_bits(2));
            emit(enc_j(21'((2 * n + 1) * 4), 5'd5));
            tx_block(n);
            send_word(5'd5);
            emit({20'd0, 5'd6, rv_pkg::OPC_AUIPC});
            emit(enc_i(12'((2 * n + 2) * 4 + 1), 5'd6, 3'd0, 5'd7, rv_pkg::OPC_JALR));
            tx_block(n);
            send_word(5'd7);
        end
        run_test("jump");

        start_program();
        init_regs();
        for (int k = 0; k < 16; k++) begin
            t  = rand_bits(2);
            rd = rand_reg();
            case (t[1:0])
                2'd0: send(rd);
                2'd1: emit(enc_sb(12'h001, rd, BASE));
                2'd2: emit(enc_sb(12'hff0, rd, BASE));
                default: emit(enc_sb(12'h000, rd, 5'd1));
            endcase
        end
        run_test("store");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
hw/rv_pkg.sv
hw/stage_reg.sv
hw/fetch_unit.sv
hw/decode.sv
hw/register_file.sv
hw/execute.sv
hw/result.sv
hw/rv_core_top.sv
tb/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f rv_core.f --top-module tb_rv_core -o sim_tb_rv_core \
    && ./obj_dir/sim_tb_rv_core > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -qx "No errors" sim.log && exit 0 || exit 1
